// File: source/issue_pkg.sv
package issue_pkg;

  // ------------------------------------------------------------------
  // Instruction classes and decoded operation flags
  // ------------------------------------------------------------------

  typedef enum logic [2:0] {
    op_alu,
    op_load,
    op_store,
    op_branch,
    op_csr_rw,
    op_fpu,
    op_fload,
    op_fstore
  } op_kind_e;

  typedef struct packed {
    logic rden1;
    logic rden2;
    logic wren;
    logic fwren;
    logic frden1;
    logic frden2;
    logic frden3;
    logic crden;
    logic cwren;
    logic fpu;
    logic fpuf;     // Updates fflags
    logic fload;
    logic fstore;
    logic load;
  } op_flags_t;

  typedef struct packed {
    logic        valid;
    op_kind_e    kind;
    op_flags_t   op;
    logic [4:0]  raddr1;
    logic [4:0]  raddr2;
    logic [4:0]  raddr3;
    logic [4:0]  waddr;
    logic [11:0] caddr;
    logic [2:0]  rm;
    logic [1:0]  fmt;
    logic [31:0] cdata;
  } instr_t;

  typedef struct packed {
    logic   stall;
    instr_t instr0;
    instr_t instr1;
  } stage_info_t;

  typedef struct packed {
    logic       rden1;
    logic       rden2;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
  } reg_read_t;

  typedef struct packed {
    logic        crden;
    logic [11:0] craddr;
  } csr_read_t;

  typedef struct packed {
    instr_t instr0;
    instr_t instr1;
    logic   swap;    // instr0 is the deferred second slot
    logic   stall;
  } issue_out_t;

  // ------------------------------------------------------------------
  // CSR addresses and init values
  // ------------------------------------------------------------------

  localparam logic [11:0] csr_fflags  = 12'h001;
  localparam logic [11:0] csr_frm     = 12'h002;
  localparam logic [11:0] csr_fcsr    = 12'h003;
  localparam logic [11:0] csr_mstatus = 12'h300;

  localparam logic [2:0] rm_dynamic = 3'b111;

  localparam op_flags_t  init_operation   = '0;
  localparam instr_t     init_instruction = '0;
  localparam issue_out_t init_issue_out   = '0;

endpackage

// File: source/hazard_pair.sv
`timescale 1ns/1ps

module hazard_pair (
  input  logic              clock,
  input  logic              reset,
  input  issue_pkg::instr_t in0,
  input  issue_pkg::instr_t in1,
  input  logic              flush,
  output issue_pkg::instr_t out0,
  output issue_pkg::instr_t out1,
  output logic              swap,
  output logic              stall
);
  import issue_pkg::*;

  instr_t buf_instr;
  logic   buf_valid;
  logic   raw_dep;
  logic   mem_pair;
  logic   solo_kind;
  logic   defer;

  function automatic logic is_mem(instr_t i);
    return i.op.load | i.op.fload | i.op.fstore | (i.kind == op_store);
  endfunction

  // ------------------------------------------------------------------
  // Pairing rules
  // ------------------------------------------------------------------

  always_comb begin
    raw_dep = in0.op.wren && (in0.waddr != 5'd0) &&
              ((in1.op.rden1 && (in1.raddr1 == in0.waddr)) ||
               (in1.op.rden2 && (in1.raddr2 == in0.waddr)));
    mem_pair = is_mem(in0) && is_mem(in1);  // Single memory port
    solo_kind = (in1.kind == op_csr_rw) || in1.op.fpu || in1.op.fload || in1.op.fstore;
    defer = !buf_valid && in0.valid && in1.valid && (raw_dep || mem_pair || solo_kind);
  end

  always_comb begin
    out0 = in0;
    out1 = in1;
    swap = 1'b0;
    stall = 1'b0;
    if (buf_valid) begin
      out0 = buf_instr;          // Second half goes out alone
      out1 = init_instruction;
      swap = 1'b1;
    end else if (defer) begin
      out1 = init_instruction;
      stall = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      buf_valid <= 1'b0;
    end else if (flush) begin
      buf_valid <= 1'b0;
    end else begin
      buf_valid <= defer;        // Drains after one cycle
    end
  end

  always_ff @(posedge clock) begin
    if (defer) begin
      buf_instr <= in1;
    end
  end

endmodule

// File: source/int_regfile.sv
`timescale 1ns/1ps

module int_regfile (
  input  logic                 clock,
  input  logic                 reset,
  input  issue_pkg::reg_read_t rin0,
  input  issue_pkg::reg_read_t rin1,
  input  logic                 wren,
  input  logic [4:0]           waddr,
  input  logic [31:0]          wdata,
  output logic [31:0]          rdata0_1,
  output logic [31:0]          rdata0_2,
  output logic [31:0]          rdata1_1,
  output logic [31:0]          rdata1_2
);

  logic [31:0] regs [0:31];

  // Asynchronous reads, x0 and disabled ports give zero
  assign rdata0_1 = (rin0.rden1 && (rin0.raddr1 != 5'd0)) ? regs[rin0.raddr1] : 32'd0;
  assign rdata0_2 = (rin0.rden2 && (rin0.raddr2 != 5'd0)) ? regs[rin0.raddr2] : 32'd0;
  assign rdata1_1 = (rin1.rden1 && (rin1.raddr1 != 5'd0)) ? regs[rin1.raddr1] : 32'd0;
  assign rdata1_2 = (rin1.rden2 && (rin1.raddr2 != 5'd0)) ? regs[rin1.raddr2] : 32'd0;

  always_ff @(posedge clock) begin
    if (reset && wren && (waddr != 5'd0)) begin  // Writes blocked in reset
      regs[waddr] <= wdata;
    end
  end

endmodule

// File: source/csr_file.sv
`timescale 1ns/1ps

module csr_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [11:0] craddr,
  input  logic        crden,
  input  logic        wren,
  input  logic [11:0] waddr,
  input  logic [31:0] wdata,
  output logic [1:0]  fs,
  output logic [2:0]  frm,
  output logic [31:0] cdata
);
  import issue_pkg::*;

  logic [1:0] fs_q;
  logic [2:0] frm_q;
  logic [4:0] fflags_q;

  assign fs = fs_q;
  assign frm = frm_q;

  always_comb begin
    cdata = 32'd0;
    if (crden) begin
      case (craddr)
        csr_fflags:  cdata = {27'd0, fflags_q};
        csr_frm:     cdata = {29'd0, frm_q};
        csr_fcsr:    cdata = {24'd0, frm_q, fflags_q};
        csr_mstatus: cdata = {17'd0, fs_q, 13'd0};  // fs at bits 14:13
        default:     cdata = 32'd0;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      fs_q <= 2'b00;               // FP unit off
      frm_q <= 3'b000;
      fflags_q <= 5'b00000;
    end else if (wren) begin
      case (waddr)
        csr_fflags:  fflags_q <= wdata[4:0];
        csr_frm:     frm_q <= wdata[2:0];
        csr_fcsr:    {frm_q, fflags_q} <= wdata[7:0];
        csr_mstatus: fs_q <= wdata[14:13];
        default:     ;
      endcase
    end
  end

endmodule

// File: source/issue_stage.sv
`timescale 1ns/1ps

module issue_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  issue_pkg::instr_t      dec_instr0,
  input  issue_pkg::instr_t      dec_instr1,
  input  issue_pkg::stage_info_t ex_info,
  input  issue_pkg::stage_info_t mem_info,
  input  logic                   trap,
  input  logic                   pred_miss,
  input  issue_pkg::instr_t      haz_out0,
  input  issue_pkg::instr_t      haz_out1,
  input  logic                   haz_swap,
  input  logic                   haz_stall,
  output issue_pkg::instr_t      haz_in0,
  output issue_pkg::instr_t      haz_in1,
  output logic                   haz_flush,
  input  logic [1:0]             fs,
  input  logic [2:0]             frm,
  input  logic [31:0]            cdata,
  output issue_pkg::csr_read_t   csr_rin,
  output issue_pkg::reg_read_t   reg_rin0,
  output issue_pkg::reg_read_t   reg_rin1,
  output issue_pkg::issue_out_t  y,
  output issue_pkg::issue_out_t  q
);
  import issue_pkg::*;

  issue_out_t r;
  issue_out_t v;
  logic       clear;
  logic       csr_wait;
  logic       flag_wait;
  logic       use_wait;
  logic       hold;

  function automatic instr_t mask_fp(instr_t i);
    instr_t m;
    m = i;
    m.op.fwren = 1'b0;
    m.op.frden1 = 1'b0;
    m.op.frden2 = 1'b0;
    m.op.frden3 = 1'b0;
    m.op.fpu = 1'b0;
    m.op.fpuf = 1'b0;
    m.op.fload = 1'b0;
    m.op.fstore = 1'b0;
    m.fmt = 2'b00;
    m.rm = 3'b000;
    return m;
  endfunction

  // Load in execute feeding a source of i
  function automatic logic load_use(instr_t e, instr_t i);
    logic int_hit;
    logic fp_hit;
    int_hit = (i.op.rden1 && (i.raddr1 == e.waddr)) || (i.op.rden2 && (i.raddr2 == e.waddr));
    fp_hit = (i.op.frden1 && (i.raddr1 == e.waddr)) ||
             (i.op.frden2 && (i.raddr2 == e.waddr)) ||
             (i.op.frden3 && (i.raddr3 == e.waddr));
    return (e.op.load && int_hit) || (e.op.fload && fp_hit);
  endfunction

  assign haz_in0 = dec_instr0;
  assign haz_in1 = dec_instr1;
  assign csr_rin.crden = haz_out0.op.crden;
  assign csr_rin.craddr = haz_out0.caddr;

  // ------------------------------------------------------------------
  // Issue decision
  // ------------------------------------------------------------------

  always_comb begin
    v.instr0 = haz_out0;
    v.instr1 = haz_out1;
    v.swap = haz_swap;
    v.stall = haz_stall;
    if (fs == 2'b00) begin
      v.instr0 = mask_fp(v.instr0);
      v.instr1 = mask_fp(v.instr1);
    end
    if (v.instr0.rm == rm_dynamic) v.instr0.rm = frm;
    if (v.instr1.rm == rm_dynamic) v.instr1.rm = frm;
    v.instr0.cdata = cdata;

    csr_wait = ex_info.instr0.op.cwren | ex_info.instr1.op.cwren |
               mem_info.instr0.op.cwren | mem_info.instr1.op.cwren;
    flag_wait = v.instr0.op.crden &&
                ((v.instr0.caddr == csr_fflags) || (v.instr0.caddr == csr_fcsr)) &&
                (ex_info.instr0.op.fpuf | ex_info.instr1.op.fpuf |
                 mem_info.instr0.op.fpuf | mem_info.instr1.op.fpuf);
    use_wait = load_use(ex_info.instr0, v.instr0) | load_use(ex_info.instr1, v.instr0) |
               load_use(ex_info.instr0, v.instr1) | load_use(ex_info.instr1, v.instr1);
    hold = csr_wait | flag_wait | use_wait | ex_info.stall | mem_info.stall;

    if (hold) begin
      v.instr0.op = init_operation;   // Bubble
      v.instr1.op = init_operation;
      v.stall = 1'b1;
    end

    clear = trap | pred_miss;
    if (clear) v = init_issue_out;
    haz_flush = clear | hold;
  end

  assign y = v;
  assign q = r;

  always_comb begin
    reg_rin0.rden1 = r.instr0.op.rden1;
    reg_rin0.rden2 = r.instr0.op.rden2;
    reg_rin0.raddr1 = r.instr0.raddr1;
    reg_rin0.raddr2 = r.instr0.raddr2;
    reg_rin1.rden1 = r.instr1.op.rden1;
    reg_rin1.rden2 = r.instr1.op.rden2;
    reg_rin1.raddr1 = r.instr1.raddr1;
    reg_rin1.raddr2 = r.instr1.raddr2;
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      r <= init_issue_out;
    end else begin
      r <= v;
    end
  end

endmodule

// File: source/issue_top.sv
`timescale 1ns/1ps

module issue_top (
  input  logic                   clock,
  input  logic                   reset,
  input  issue_pkg::instr_t      dec_instr0,
  input  issue_pkg::instr_t      dec_instr1,
  input  issue_pkg::stage_info_t ex_info,
  input  issue_pkg::stage_info_t mem_info,
  input  logic                   trap,
  input  logic                   pred_miss,
  input  logic                   wb_wren,
  input  logic [4:0]             wb_waddr,
  input  logic [31:0]            wb_wdata,
  input  logic                   csr_wren,
  input  logic [11:0]            csr_waddr,
  input  logic [31:0]            csr_wdata,
  output issue_pkg::issue_out_t  issue_q,
  output logic [31:0]            rdata0_1,
  output logic [31:0]            rdata0_2,
  output logic [31:0]            rdata1_1,
  output logic [31:0]            rdata1_2,
  output logic                   stall_out
);
  import issue_pkg::*;

  instr_t     haz_in0;
  instr_t     haz_in1;
  instr_t     haz_out0;
  instr_t     haz_out1;
  logic       haz_flush;
  logic       haz_swap;
  logic       haz_stall;
  logic [1:0] fs;
  logic [2:0] frm;
  logic [31:0] cdata;
  csr_read_t  csr_rin;
  reg_read_t  reg_rin0;
  reg_read_t  reg_rin1;
  issue_out_t y;

  assign stall_out = y.stall;

  issue_stage u_issue_stage (
    .clock(clock), .reset(reset),
    .dec_instr0(dec_instr0), .dec_instr1(dec_instr1),
    .ex_info(ex_info), .mem_info(mem_info),
    .trap(trap), .pred_miss(pred_miss),
    .haz_out0(haz_out0), .haz_out1(haz_out1),
    .haz_swap(haz_swap), .haz_stall(haz_stall),
    .haz_in0(haz_in0), .haz_in1(haz_in1), .haz_flush(haz_flush),
    .fs(fs), .frm(frm), .cdata(cdata),
    .csr_rin(csr_rin), .reg_rin0(reg_rin0), .reg_rin1(reg_rin1),
    .y(y), .q(issue_q)
  );

  hazard_pair u_hazard_pair (
    .clock(clock), .reset(reset),
    .in0(haz_in0), .in1(haz_in1), .flush(haz_flush),
    .out0(haz_out0), .out1(haz_out1), .swap(haz_swap), .stall(haz_stall)
  );

  int_regfile u_int_regfile (
    .clock(clock), .reset(reset),
    .rin0(reg_rin0), .rin1(reg_rin1),
    .wren(wb_wren), .waddr(wb_waddr), .wdata(wb_wdata),
    .rdata0_1(rdata0_1), .rdata0_2(rdata0_2),
    .rdata1_1(rdata1_1), .rdata1_2(rdata1_2)
  );

  csr_file u_csr_file (
    .clock(clock), .reset(reset),
    .craddr(csr_rin.craddr), .crden(csr_rin.crden),
    .wren(csr_wren), .waddr(csr_waddr), .wdata(csr_wdata),
    .fs(fs), .frm(frm), .cdata(cdata)
  );

endmodule

// File: tb/issue_assert.sv
`timescale 1ns/1ps

module issue_assert (
  input logic                   clock,
  input logic                   reset,
  input issue_pkg::instr_t      dec_instr0,
  input issue_pkg::instr_t      dec_instr1,
  input issue_pkg::stage_info_t ex_info,
  input issue_pkg::stage_info_t mem_info,
  input logic                   trap,
  input logic                   pred_miss,
  input logic                   haz_stall,
  input logic                   haz_swap,
  input logic                   haz_flush,
  input logic [1:0]             fs,
  input issue_pkg::issue_out_t  issue_q,
  input logic                   stall_out,
  input logic [31:0]            rdata0_1,
  input logic [31:0]            rdata1_1
);
  import issue_pkg::*;

  int         fail_count = 0;
  logic [7:0] fp_bits0;
  logic [7:0] fp_bits1;

  assign fp_bits0 = {issue_q.instr0.op.fwren, issue_q.instr0.op.frden1,
                     issue_q.instr0.op.frden2, issue_q.instr0.op.frden3,
                     issue_q.instr0.op.fpu, issue_q.instr0.op.fpuf,
                     issue_q.instr0.op.fload, issue_q.instr0.op.fstore};
  assign fp_bits1 = {issue_q.instr1.op.fwren, issue_q.instr1.op.frden1,
                     issue_q.instr1.op.frden2, issue_q.instr1.op.frden3,
                     issue_q.instr1.op.fpu, issue_q.instr1.op.fpuf,
                     issue_q.instr1.op.fload, issue_q.instr1.op.fstore};

  // Two ALU ops with no shared register go out together
  a_dual: assert property (@(posedge clock) disable iff (!reset)
    dec_instr0.valid && dec_instr1.valid &&
    dec_instr0.kind == op_alu && dec_instr1.kind == op_alu &&
    dec_instr1.raddr1 != dec_instr0.waddr && dec_instr1.raddr2 != dec_instr0.waddr &&
    ex_info == '0 && mem_info == '0 && !haz_swap && !trap && !pred_miss
    |=> issue_q.instr0.valid && issue_q.instr1.valid && !issue_q.swap)
    else begin
      fail_count++;
      $error("dual issue");
    end

  // Deferred instr1 comes out one cycle after instr0
  a_defer: assert property (@(posedge clock) disable iff (!reset)
    haz_stall && !haz_flush |=> !issue_q.instr1.valid ##1
    (issue_q.swap || $past(trap || pred_miss)))
    else begin
      fail_count++;
      $error("defer order");
    end

  a_load_use: assert property (@(posedge clock) disable iff (!reset)
    ex_info.instr0.op.load && dec_instr0.valid && dec_instr0.op.rden1 &&
    dec_instr0.raddr1 == ex_info.instr0.waddr && !haz_swap && !trap && !pred_miss
    |-> stall_out ##1 (issue_q.instr0.op == init_operation &&
    issue_q.instr1.op == init_operation && issue_q.stall))
    else begin
      fail_count++;
      $error("load-use bubble");
    end

  a_fs_off: assert property (@(posedge clock) disable iff (!reset)
    fs == 2'b00 |=> fp_bits0 == 8'd0 && fp_bits1 == 8'd0)
    else begin
      fail_count++;
      $error("fp flags");
    end

  a_flush: assert property (@(posedge clock) disable iff (!reset)
    trap || pred_miss |-> !stall_out ##1 issue_q == init_issue_out)
    else begin
      fail_count++;
      $error("flush");
    end

  a_x0: assert property (@(posedge clock) disable iff (!reset)
    (issue_q.instr0.raddr1 == 5'd0 |-> rdata0_1 == 32'd0) and
    (issue_q.instr1.raddr1 == 5'd0 |-> rdata1_1 == 32'd0))
    else begin
      fail_count++;
      $error("x0 read");
    end

endmodule

bind issue_top issue_assert u_issue_assert (
  .clock(clock), .reset(reset),
  .dec_instr0(dec_instr0), .dec_instr1(dec_instr1),
  .ex_info(ex_info), .mem_info(mem_info),
  .trap(trap), .pred_miss(pred_miss),
  .haz_stall(haz_stall), .haz_swap(haz_swap), .haz_flush(haz_flush), .fs(fs),
  .issue_q(issue_q), .stall_out(stall_out),
  .rdata0_1(rdata0_1), .rdata1_1(rdata1_1)
);

// File: tb/tb_issue.sv
`timescale 1ns/1ps

module tb_issue;
  import issue_pkg::*;

  logic        clock;
  logic        reset;
  instr_t      dec_instr0;
  instr_t      dec_instr1;
  stage_info_t ex_info;
  stage_info_t mem_info;
  logic        trap;
  logic        pred_miss;
  logic        wb_wren;
  logic [4:0]  wb_waddr;
  logic [31:0] wb_wdata;
  logic        csr_wren;
  logic [11:0] csr_waddr;
  logic [31:0] csr_wdata;
  issue_out_t  issue_q;
  logic [31:0] rdata0_1;
  logic [31:0] rdata0_2;
  logic [31:0] rdata1_1;
  logic [31:0] rdata1_2;
  logic        stall_out;

  logic [31:0] shadow [0:31];
  logic [15:0] lfsr;
  int          errors;
  int          tests;

  localparam int num_random = 200;

  issue_top u_issue_top (.*);

  always #10 clock = ~clock;

  // Galois LFSR, one step per bit
  function logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic instr_t make_instr(op_kind_e k, logic [4:0] rd, logic [4:0] rs1,
                                        logic [4:0] rs2, logic en1, logic en2);
    instr_t i;
    i = init_instruction;
    i.valid = 1'b1;
    i.kind = k;
    i.op.rden1 = en1;
    i.op.rden2 = en2;
    i.op.wren = (k == op_alu) || (k == op_load);
    i.op.load = (k == op_load);
    i.raddr1 = rs1;
    i.raddr2 = rs2;
    i.waddr = rd;
    return i;
  endfunction

  function automatic logic touches_mem(instr_t i);
    return (i.kind == op_load) || (i.kind == op_store);
  endfunction

  function automatic logic [31:0] exp_read(logic en, logic [4:0] a);
    return (en && (a != 5'd0)) ? shadow[a] : 32'd0;
  endfunction

  task automatic check(input logic cond, input string msg);
    assert (cond) else begin
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic next_cycle();
    @(posedge clock);
    #2;
  endtask

  task automatic check_reads();
    check(rdata0_1 == exp_read(issue_q.instr0.op.rden1, issue_q.instr0.raddr1), "rdata0_1");
    check(rdata0_2 == exp_read(issue_q.instr0.op.rden2, issue_q.instr0.raddr2), "rdata0_2");
    check(rdata1_1 == exp_read(issue_q.instr1.op.rden1, issue_q.instr1.raddr1), "rdata1_1");
    check(rdata1_2 == exp_read(issue_q.instr1.op.rden2, issue_q.instr1.raddr2), "rdata1_2");
  endtask

  task automatic wait_stall_clear();
    int n;
    n = 0;
    while (stall_out && n < 10) begin
      next_cycle();
      @(negedge clock);
      n++;
    end
    check(!stall_out, "stall_out never dropped after the hazard cleared");
  endtask

  // Pair issue with the pairing rules applied to the expected result
  task automatic run_pair(input instr_t i0, input instr_t i1);
    logic defer;
    defer = (i0.op.wren && (i0.waddr != 5'd0) &&
             ((i1.op.rden1 && i1.raddr1 == i0.waddr) ||
              (i1.op.rden2 && i1.raddr2 == i0.waddr))) ||
            (touches_mem(i0) && touches_mem(i1));
    dec_instr0 = i0;
    dec_instr1 = i1;
    @(negedge clock);
    check(stall_out == defer, "stall_out for pair");
    next_cycle();
    dec_instr0 = init_instruction;
    dec_instr1 = init_instruction;
    @(negedge clock);
    check(issue_q.instr0 == i0, "issue_q.instr0");
    check(issue_q.instr1 == (defer ? init_instruction : i1), "issue_q.instr1");
    check(!issue_q.swap, "swap set on first issue");
    check_reads();
    if (defer) begin
      next_cycle();
      @(negedge clock);
      check(issue_q.instr0 == i1 && issue_q.swap, "deferred instr1 not issued with swap");
      check_reads();
    end
    next_cycle();
  endtask

  task automatic report(input string name);
    tests++;
    $display("test %-12s done, errors so far %0d", name, errors);
  endtask

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  initial begin
    instr_t a;
    instr_t b;
    clock = 1'b0;
    reset = 1'b0;
    dec_instr0 = init_instruction;
    dec_instr1 = init_instruction;
    ex_info = '0;
    mem_info = '0;
    trap = 1'b0;
    pred_miss = 1'b0;
    wb_wren = 1'b0;
    wb_waddr = 5'd0;
    wb_wdata = 32'd0;
    csr_wren = 1'b0;
    csr_waddr = 12'd0;
    csr_wdata = 32'd0;
    lfsr = 16'd96;
    errors = 0;
    tests = 0;
    shadow[0] = 32'd0;
    repeat (8) @(posedge clock);
    #2;
    reset = 1'b1;
    @(negedge clock);
    check(issue_q == init_issue_out && !stall_out, "state after reset");
    report("reset");
    next_cycle();

    wb_wren = 1'b1;
    for (int r = 1; r < 32; r++) begin
      wb_waddr = 5'(r);
      wb_wdata = 32'h5a00_0000 ^ (32'(r) * 32'h0101_0103);
      shadow[r] = wb_wdata;
      next_cycle();
    end
    wb_wren = 1'b0;

    run_pair(make_instr(op_alu, 5, 1, 2, 1, 1), make_instr(op_alu, 6, 3, 4, 1, 1));
    run_pair(make_instr(op_alu, 0, 0, 9, 1, 1), make_instr(op_alu, 6, 0, 4, 1, 0));
    report("dual_issue");
    run_pair(make_instr(op_alu, 5, 1, 2, 1, 1), make_instr(op_alu, 6, 5, 4, 1, 1));
    run_pair(make_instr(op_load, 5, 1, 2, 1, 0), make_instr(op_store, 0, 3, 4, 1, 1));
    report("defer");

    a = make_instr(op_alu, 8, 7, 2, 1, 1);
    ex_info.instr0 = make_instr(op_load, 7, 1, 0, 1, 0);
    dec_instr0 = a;
    @(negedge clock);
    check(stall_out, "load-use hazard did not stall");
    next_cycle();
    ex_info = '0;
    @(negedge clock);
    check(issue_q.instr0.op == init_operation && issue_q.stall, "load-use bubble");
    wait_stall_clear();
    next_cycle();
    @(negedge clock);
    check(issue_q.instr0 == a, "pair after load-use");
    next_cycle();
    dec_instr0 = init_instruction;
    report("load_use");

    mem_info.instr0.op.cwren = 1'b1;
    dec_instr0 = a;
    @(negedge clock);
    check(stall_out, "CSR write in memory did not stall");
    next_cycle();
    mem_info = '0;
    @(negedge clock);
    check(issue_q.instr0.op == init_operation, "CSR hazard bubble");
    wait_stall_clear();
    next_cycle();
    dec_instr0 = init_instruction;
    report("csr_hazard");

    a = make_instr(op_fpu, 3, 1, 2, 0, 0);
    a.op.wren = 1'b0;
    a.op.fpu = 1'b1;
    a.op.fwren = 1'b1;
    a.op.frden1 = 1'b1;
    a.rm = rm_dynamic;
    a.fmt = 2'b01;
    b = a;
    b.op.fpu = 1'b0;
    b.op.fwren = 1'b0;
    b.op.frden1 = 1'b0;
    b.rm = 3'b000;
    b.fmt = 2'b00;
    dec_instr0 = a;
    next_cycle();
    @(negedge clock);
    check(issue_q.instr0 == b, "FP op not masked with fs off");
    next_cycle();
    dec_instr0 = init_instruction;
    csr_wren = 1'b1;
    csr_waddr = csr_mstatus;
    csr_wdata = 32'h0000_2000;        // fs = 1
    next_cycle();
    csr_waddr = csr_frm;
    csr_wdata = 32'd3;
    next_cycle();
    csr_wren = 1'b0;
    a.op.crden = 1'b1;
    a.caddr = csr_frm;
    b = a;
    b.rm = 3'd3;
    b.cdata = 32'd3;
    dec_instr0 = a;
    next_cycle();
    @(negedge clock);
    check(issue_q.instr0 == b, "dynamic rm or CSR data with fs on");
    next_cycle();
    dec_instr0 = init_instruction;
    report("fp_gate");

    trap = 1'b1;
    dec_instr0 = make_instr(op_alu, 5, 1, 2, 1, 1);
    dec_instr1 = make_instr(op_alu, 6, 5, 2, 1, 1);
    @(negedge clock);
    check(!stall_out, "stall_out high during trap");
    next_cycle();
    trap = 1'b0;
    pred_miss = 1'b1;
    @(negedge clock);
    check(issue_q == init_issue_out, "issue_q not cleared by trap");
    next_cycle();
    pred_miss = 1'b0;
    dec_instr0 = init_instruction;
    dec_instr1 = init_instruction;
    @(negedge clock);
    check(issue_q == init_issue_out, "issue_q not cleared by mispredict");
    next_cycle();
    report("flush");

    for (int n = 0; n < num_random; n++) begin
      a = make_instr(op_kind_e'(rand_bits(2)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                     5'(rand_bits(5)), rand_bits(1) == 1, rand_bits(1) == 1);
      b = make_instr(op_kind_e'(rand_bits(2)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                     5'(rand_bits(5)), rand_bits(1) == 1, rand_bits(1) == 1);
      run_pair(a, b);
    end
    report("random");

    errors += u_issue_top.u_issue_assert.fail_count;
    $display("tests %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    #((300 + 2 * num_random) * 20);
    $display("Timeout: the tests did not finish in the expected time");
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: src.f
source/issue_pkg.sv
source/hazard_pair.sv
source/int_regfile.sv
source/csr_file.sv
source/issue_stage.sv
source/issue_top.sv
tb/issue_assert.sv
tb/tb_issue.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_issue -f src.f -o tb_issue
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/tb_issue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^\*\* PASS \*\*$" sim.log; then
  exit 0
fi
exit 1
